// File: hw/mmuPkg.sv
// MMU types: address and descriptor widths, fault codes, bus structs, walker states
`default_nettype none

package mmuPkg;

  // ==================================================
  // Widths with a meaning
  // ==================================================
  typedef logic [31:0] vaddr_t;   // Virtual address from the core
  typedef logic [31:0] paddr_t;   // Physical address after translation
  typedef logic [31:0] desc_t;    // Raw page table word
  typedef logic [3:0]  domain_t;  // One of 16 domains
  typedef logic [1:0]  apBits_t;  // Access permission field
  typedef logic [1:0]  regSel_t;  // Config register select

  // Config register select values
  localparam regSel_t REG_CTRL = 2'd0;
  localparam regSel_t REG_TTB  = 2'd1;
  localparam regSel_t REG_DACR = 2'd2;

  // Control register bit positions, CP15 c1 layout
  localparam int CTRL_M_BIT = 0;
  localparam int CTRL_S_BIT = 8;
  localparam int CTRL_R_BIT = 9;

  // First-level descriptor types
  localparam logic [1:0] DESC_FAULT   = 2'b00;
  localparam logic [1:0] DESC_COARSE  = 2'b01;
  localparam logic [1:0] DESC_SECTION = 2'b10;

  // Second-level descriptor types
  localparam logic [1:0] PAGE_FAULT = 2'b00;
  localparam logic [1:0] PAGE_LARGE = 2'b01;
  localparam logic [1:0] PAGE_SMALL = 2'b10;

  // Domain access values
  localparam logic [1:0] DOM_CLIENT  = 2'b01;
  localparam logic [1:0] DOM_MANAGER = 2'b11;

  // ==================================================
  // Fault status codes
  // ==================================================
  typedef enum logic [3:0] {
    FC_NONE       = 4'b0000,  // No fault
    FC_ALIGN      = 4'b0001,
    FC_TRANS_SEC  = 4'b0101,
    FC_TRANS_PAGE = 4'b0111,
    FC_DOM_SEC    = 4'b1001,
    FC_DOM_PAGE   = 4'b1011,
    FC_PERM_SEC   = 4'b1101,
    FC_PERM_PAGE  = 4'b1111,
    FC_EXT_L1     = 4'b1100,  // Abort on first-level fetch
    FC_EXT_L2     = 4'b1110   // Abort on second-level fetch
  } faultCode_e;

  typedef enum logic [2:0] {
    IDLE, L1REQ, L1WAIT, L2REQ, L2WAIT, CHECK, RESP
  } walkState_e;

  // ==================================================
  // Structs
  // ==================================================
  typedef struct packed {
    vaddr_t vaddr;
    logic   write;
    logic   supervisor;
    logic   dataAccess;
    logic   wordAccess;
  } transReq_t;

  typedef struct packed {
    paddr_t     paddr;
    logic       fault;
    faultCode_e faultCode;
  } transResp_t;

  typedef struct packed {
    desc_t data;
    logic  extAbort;
  } memResp_t;

  typedef struct packed {
    regSel_t     regSel;
    logic [31:0] data;
  } cfgWrite_t;

  typedef struct packed {
    logic       fault;
    faultCode_e faultCode;
    domain_t    domain;
    vaddr_t     vaddr;
  } faultInfo_t;

  typedef struct packed {
    logic enable;  // M bit
    logic sBit;    // System protection
    logic rBit;    // ROM protection
  } ctrl_t;

endpackage

`default_nettype wire

// File: hw/transReqQueue.sv
// Translation request FIFO, one credit returned per popped entry
`default_nettype none
`timescale 1ns/1ps

module transReqQueue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              reqValid,
  input  mmuPkg::transReq_t req,
  input  logic              pop,
  output logic              headValid,
  output mmuPkg::transReq_t head,
  output logic              creditReturn
);
  import mmuPkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  transReq_t        entries [QUEUE_DEPTH];  // Circular buffer
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;                  // Occupied entries
  logic             doPop;

  assign headValid = (count != '0);  // Registered count, so a push shows next cycle
  assign head      = entries[rdPtr];
  assign doPop     = pop && headValid;

  // Storage
  always_ff @(posedge clk) begin
    if (reqValid) begin
      entries[wrPtr] <= req;
    end
  end

  // Pointers, occupancy, credit pulse
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      creditReturn <= doPop;  // One credit back per pop
      if (reqValid) begin
        wrPtr <= (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({reqValid, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither, occupancy unchanged
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/tableWalker.sv
// Two-level table walk FSM: descriptor fetch, check sequencing, physical address build
`default_nettype none
`timescale 1ns/1ps

module tableWalker (
  input  logic               clk,
  input  logic               rstN,
  input  logic               headValid,
  input  mmuPkg::transReq_t  head,
  output logic               pop,
  input  mmuPkg::ctrl_t      ctrl,
  input  mmuPkg::paddr_t     tableBase,
  output logic               memReqValid,
  output mmuPkg::paddr_t     memAddr,
  input  logic               memRespValid,
  input  mmuPkg::memResp_t   memResp,
  output logic               level2,
  output mmuPkg::desc_t      desc,
  output logic               descValid,
  output logic               memErr,
  output mmuPkg::transReq_t  curReq,
  output mmuPkg::domain_t    l1Domain,
  input  mmuPkg::faultInfo_t checkFault,
  output logic               respValid,
  output mmuPkg::transResp_t resp
);
  import mmuPkg::*;

  walkState_e state;
  walkState_e nextState;
  logic       headBypass;  // Disabled or misaligned, no walk
  logic       goLevel2;
  logic       readDone;
  paddr_t     paddr;

  assign headBypass = !ctrl.enable ||
                      (head.wordAccess && (head.vaddr[1:0] != 2'b00));
  assign readDone   = memRespValid && (state == L1WAIT || state == L2WAIT);
  // Clean coarse entry at level 1 means one more fetch
  assign goLevel2   = descValid && !level2 && !checkFault.fault &&
                      (desc[1:0] == DESC_COARSE);

  assign pop         = (state == IDLE) && headValid;
  assign memReqValid = (state == L1REQ) || (state == L2REQ);
  assign respValid   = (state == RESP);

  // L2 address uses the still-held L1 descriptor
  assign memAddr = level2 ? {desc[31:10], curReq.vaddr[19:12], 2'b00}
                          : {tableBase[31:14], curReq.vaddr[31:20], 2'b00};

  // ==================================================
  // Next state
  // ==================================================
  always_comb begin
    nextState = state;
    case (state)
      IDLE:    if (headValid) nextState = headBypass ? CHECK : L1REQ;
      L1REQ:   nextState = L1WAIT;
      L1WAIT:  if (memRespValid) nextState = CHECK;
      L2REQ:   nextState = L2WAIT;
      L2WAIT:  if (memRespValid) nextState = CHECK;
      CHECK:   nextState = goLevel2 ? L2REQ : RESP;  // Any fault ends the walk
      RESP:    nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  // Physical address from section or page base
  always_comb begin
    if (!ctrl.enable) begin
      paddr = curReq.vaddr;  // Flat mapping
    end else if (checkFault.fault) begin
      paddr = '0;
    end else if (!level2) begin
      paddr = {desc[31:20], curReq.vaddr[19:0]};  // Section
    end else if (desc[1:0] == PAGE_LARGE) begin
      paddr = {desc[31:16], curReq.vaddr[15:0]};
    end else begin
      paddr = {desc[31:12], curReq.vaddr[11:0]};  // Small page
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= IDLE;
      level2    <= 1'b0;
      descValid <= 1'b0;
    end else begin
      state <= nextState;
      if (pop) begin
        level2    <= 1'b0;
        descValid <= 1'b0;
      end
      if (readDone) descValid <= 1'b1;
      if (state == CHECK && goLevel2) level2 <= 1'b1;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (pop) curReq <= head;
    if (readDone) begin
      desc   <= memResp.data;
      memErr <= memResp.extAbort;
    end
    if (state == CHECK) begin
      if (goLevel2) l1Domain <= desc[8:5];  // Pages inherit the L1 domain
      resp.paddr     <= paddr;
      resp.fault     <= checkFault.fault;
      resp.faultCode <= checkFault.faultCode;
    end
  end

endmodule

`default_nettype wire

// File: hw/faultDetect.sv
// Fault priority, domain lookup, access permission check, fault code selection
`default_nettype none
`timescale 1ns/1ps

module faultDetect (
  input  mmuPkg::ctrl_t      ctrl,
  input  logic [31:0]        dacr,
  input  mmuPkg::transReq_t  curReq,
  input  mmuPkg::desc_t      desc,
  input  logic               descValid,
  input  logic               memErr,
  input  logic               level2,
  input  mmuPkg::domain_t    l1Domain,
  output mmuPkg::faultInfo_t checkFault
);
  import mmuPkg::*;

  domain_t    curDomain;
  logic [1:0] dPerm;       // Domain access value
  logic [1:0] apIdx;       // Subpage select
  apBits_t    curAp;
  logic       misaligned;
  logic       descInvalid;
  logic       domFault;
  logic       isClient;
  logic       apFault;
  logic       fault;
  faultCode_e code;
  domain_t    faultDomain;

  assign misaligned = curReq.wordAccess && (curReq.vaddr[1:0] != 2'b00);

  // ==================================================
  // Domain lookup
  // ==================================================
  assign curDomain = level2 ? l1Domain : desc[8:5];
  assign dPerm     = dacr[{curDomain, 1'b0} +: 2];
  assign domFault  = !dPerm[0];  // 00 and 10 both deny
  assign isClient  = (dPerm == DOM_CLIENT);  // Manager skips AP

  // Type 11 is fine or tiny at either level and not supported
  assign descInvalid = level2 ? (desc[1:0] == PAGE_FAULT || desc[1:0] == 2'b11)
                              : (desc[1:0] == DESC_FAULT || desc[1:0] == 2'b11);

  // ==================================================
  // Access permissions
  // ==================================================
  // Section AP sits where subpage 3 would be
  always_comb begin
    if (!level2) begin
      apIdx = 2'd3;
    end else if (desc[1:0] == PAGE_LARGE) begin
      apIdx = curReq.vaddr[15:14];
    end else begin
      apIdx = curReq.vaddr[11:10];
    end
  end

  assign curAp = desc[4 + 2 * apIdx +: 2];

  always_comb begin
    case (curAp)
      // Read only and only via S or R
      2'b00:   apFault = curReq.write ||
                         !((ctrl.sBit && curReq.supervisor) || ctrl.rBit);
      2'b01:   apFault = !curReq.supervisor;                  // Privileged only
      2'b10:   apFault = !curReq.supervisor && curReq.write;  // User read only
      default: apFault = 1'b0;                                // Full access
    endcase
  end

  // ==================================================
  // Priority chain
  // ==================================================
  always_comb begin
    fault       = 1'b1;
    code        = FC_NONE;
    faultDomain = level2 ? l1Domain : '0;  // L1 faults report domain 0
    if (!ctrl.enable) begin
      fault = 1'b0;  // Flat mapping never faults
    end else if (misaligned) begin
      code        = FC_ALIGN;
      faultDomain = '0;
    end else if (!descValid) begin
      fault = 1'b0;
    end else if (memErr) begin
      code = level2 ? FC_EXT_L2 : FC_EXT_L1;
    end else if (descInvalid) begin
      code = level2 ? FC_TRANS_PAGE : FC_TRANS_SEC;
    end else if (!level2 && desc[1:0] == DESC_COARSE) begin
      fault = 1'b0;  // Domain and AP checked on the page
    end else if (domFault) begin
      code        = level2 ? FC_DOM_PAGE : FC_DOM_SEC;
      faultDomain = curDomain;
    end else if (isClient && apFault) begin
      code        = level2 ? FC_PERM_PAGE : FC_PERM_SEC;
      faultDomain = curDomain;
    end else begin
      fault = 1'b0;
    end
  end

  assign checkFault.fault     = fault;
  assign checkFault.faultCode = code;  // Stays FC_NONE on every clean path
  assign checkFault.domain    = fault ? faultDomain : '0;
  assign checkFault.vaddr     = curReq.vaddr;

endmodule

`default_nettype wire

// File: hw/faultStatusRegs.sv
// Control, table base and domain access registers, fault status and address capture
`default_nettype none
`timescale 1ns/1ps

module faultStatusRegs (
  input  logic               clk,
  input  logic               rstN,
  input  logic               cfgValid,
  input  mmuPkg::cfgWrite_t  cfg,
  input  logic               respValid,
  input  mmuPkg::faultInfo_t checkFault,
  output mmuPkg::ctrl_t      ctrl,
  output mmuPkg::paddr_t     tableBase,
  output logic [31:0]        dacr,
  output logic [7:0]         fsr,
  output mmuPkg::vaddr_t     far
);
  import mmuPkg::*;

  // ==================================================
  // Config writes and fault capture
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrl      <= '0;  // MMU off
      tableBase <= '0;
      dacr      <= '0;
      fsr       <= '0;
      far       <= '0;
    end else begin
      if (cfgValid) begin
        case (cfg.regSel)
          REG_CTRL: begin
            ctrl.enable <= cfg.data[CTRL_M_BIT];
            ctrl.sBit   <= cfg.data[CTRL_S_BIT];
            ctrl.rBit   <= cfg.data[CTRL_R_BIT];
          end
          REG_TTB:  tableBase <= {cfg.data[31:14], 14'b0};  // 16 KB aligned
          REG_DACR: dacr <= cfg.data;
          default:  ;  // Select 3 unmapped
        endcase
      end
      // Every faulting response overwrites the last one
      if (respValid && checkFault.fault) begin
        fsr <= {checkFault.domain, checkFault.faultCode};
        far <= checkFault.vaddr;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/mmuTop.sv
// MMU top level: request queue, table walker, fault logic, CP15-style registers
`default_nettype none
`timescale 1ns/1ps

module mmuTop #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rstN,
  // Core request side, credit based
  input  logic               reqValid,
  input  mmuPkg::transReq_t  req,
  output logic               creditReturn,
  output logic               respValid,
  output mmuPkg::transResp_t resp,
  // Descriptor read port
  output logic               memReqValid,
  output mmuPkg::paddr_t     memAddr,
  input  logic               memRespValid,
  input  mmuPkg::memResp_t   memResp,
  // Register access
  input  logic               cfgValid,
  input  mmuPkg::cfgWrite_t  cfg,
  output logic [7:0]         fsr,
  output mmuPkg::vaddr_t     far
);
  import mmuPkg::*;

  logic        headValid;
  transReq_t   head;
  logic        pop;
  ctrl_t       ctrl;
  paddr_t      tableBase;
  logic [31:0] dacr;
  logic        level2;
  desc_t       desc;
  logic        descValid;
  logic        memErr;
  transReq_t   curReq;
  domain_t     l1Domain;
  faultInfo_t  checkFault;

  transReqQueue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) uQueue (
    .clk, .rstN, .reqValid, .req, .pop, .headValid, .head, .creditReturn
  );

  tableWalker uWalker (
    .clk, .rstN, .headValid, .head, .pop, .ctrl, .tableBase,
    .memReqValid, .memAddr, .memRespValid, .memResp,
    .level2, .desc, .descValid, .memErr, .curReq, .l1Domain,
    .checkFault, .respValid, .resp
  );

  faultDetect uFault (
    .ctrl, .dacr, .curReq, .desc, .descValid, .memErr, .level2, .l1Domain,
    .checkFault
  );

  faultStatusRegs uRegs (
    .clk, .rstN, .cfgValid, .cfg, .respValid, .checkFault,
    .ctrl, .tableBase, .dacr, .fsr, .far
  );

endmodule

`default_nettype wire

// File: tb/mmuProps.sv
// Bound assertions: one descriptor read at a time, response spacing, queue occupancy
`default_nettype none
`timescale 1ns/1ps

module walkerProps (
  input logic clk,
  input logic rstN,
  input logic memReqValid,
  input logic memRespValid,
  input logic respValid
);
  logic readOpen;  // Read issued, answer pending
  int   readFails = 0;
  int   respFails = 0;

  always_ff @(posedge clk) begin
    if (!rstN) readOpen <= 1'b0;
    else if (memReqValid) readOpen <= 1'b1;
    else if (memRespValid) readOpen <= 1'b0;
  end

  assert property (@(posedge clk) disable iff (!rstN) memReqValid |-> !readOpen)
    else begin
      readFails++;
      $error("Descriptor read issued while another is outstanding");
    end

  assert property (@(posedge clk) disable iff (!rstN) respValid |=> !respValid)
    else begin
      respFails++;
      $error("respValid high in two consecutive cycles");
    end

endmodule

module queueProps #(
  parameter int QUEUE_DEPTH = 4,
  parameter int CNT_W       = 3
) (
  input logic             clk,
  input logic             rstN,
  input logic [CNT_W-1:0] count
);
  int depthFails = 0;

  assert property (@(posedge clk) disable iff (!rstN) count <= QUEUE_DEPTH)
    else begin
      depthFails++;
      $error("Request queue holds more than QUEUE_DEPTH entries");
    end

endmodule

`default_nettype wire

// File: tb/mmuChecker.sv
// Reference translation model, response and fault register comparison, per-test report
`default_nettype none
`timescale 1ns/1ps

module mmuChecker #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic               clk,
  input logic               rstN,
  input logic               reqValid,
  input mmuPkg::transReq_t  req,
  input logic               creditReturn,
  input logic               respValid,
  input mmuPkg::transResp_t resp,
  input logic               memReqValid,
  input mmuPkg::paddr_t     memAddr,
  input logic               memRespValid,
  input mmuPkg::memResp_t   memResp,
  input logic               cfgValid,
  input mmuPkg::cfgWrite_t  cfg,
  input logic [7:0]         fsr,
  input mmuPkg::vaddr_t     far
);
  import mmuPkg::*;

  transReq_t   reqQ [$];    // Requests in flight with the oldest walking first
  logic        abortQ [$];  // Abort flags of the current walk's reads
  int          readsSeen   = 0;
  logic        shEnable    = 1'b0;
  logic        shS         = 1'b0;
  logic        shR         = 1'b0;
  paddr_t      shTtb       = '0;
  logic [31:0] shDacr      = '0;
  logic        regCheckDue = 1'b0;
  logic [7:0]  expFsr      = '0;  // Last faulting response
  vaddr_t      expFar      = '0;
  int          errCount    = 0;
  int          respCount   = 0;
  int          reqCount    = 0;
  int          creditCount = 0;
  int          testReqBase = 0;
  int          testErrBase = 0;

  task automatic reportMismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    errCount++;
    $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
  endtask

  task automatic reportError(input string msg);
    errCount++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic closeTest(input string name);
    // One credit back per request once everything has drained
    if (creditCount != reqCount) reportMismatch("creditReturn count", reqCount, creditCount);
    $display("Test %-8s done: %0d requests, %0d errors", name,
             reqCount - testReqBase, errCount - testErrBase);
    testReqBase = reqCount;
    testErrBase = errCount;
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic apDenied(input apBits_t ap, input logic wr, input logic sup);
    case (ap)
      2'b00:   return wr || !((shS && sup) || shR);  // Read only via S or R
      2'b01:   return !sup;                          // Supervisor only
      2'b10:   return wr && !sup;                    // User may only read
      default: return 1'b0;
    endcase
  endfunction

  function automatic paddr_t descAddr(input transReq_t r, input int level);
    desc_t l1;
    l1 = mmuTb.mem[r.vaddr[31:20]];
    if (level == 0) return {shTtb[31:14], r.vaddr[31:20], 2'b00};
    return {l1[31:10], r.vaddr[19:12], 2'b00};
  endfunction

  function automatic void translate(input transReq_t r, input logic ab1, input logic ab2,
                                    output logic f, output logic [3:0] code,
                                    output domain_t dom, output paddr_t pa,
                                    output int nReads);
    desc_t      l1;
    desc_t      l2;
    paddr_t     a;
    logic [1:0] dv;
    logic [1:0] sub;
    apBits_t    ap;
    logic       isPage;
    f      = 1'b0;
    code   = FC_NONE;
    dom    = '0;
    pa     = r.vaddr;
    nReads = 0;
    if (!shEnable) return;  // Flat mapping
    if (r.wordAccess && r.vaddr[1:0] != 2'b00) begin
      f    = 1'b1;
      code = FC_ALIGN;
      return;
    end
    nReads = 1;
    a      = descAddr(r, 0);
    l1     = mmuTb.mem[a[13:2]];
    if (ab1 || l1[1:0] == 2'b00 || l1[1:0] == 2'b11) begin
      f    = 1'b1;
      code = ab1 ? FC_EXT_L1 : FC_TRANS_SEC;  // Domain stays 0 at level 1
      return;
    end
    isPage = (l1[1:0] == 2'b01);
    dom    = l1[8:5];
    ap     = l1[11:10];
    pa     = {l1[31:20], r.vaddr[19:0]};
    if (isPage) begin
      nReads = 2;
      a      = descAddr(r, 1);
      l2     = mmuTb.mem[a[13:2]];
      if (ab2 || l2[1:0] == 2'b00 || l2[1:0] == 2'b11) begin
        f    = 1'b1;
        code = ab2 ? FC_EXT_L2 : FC_TRANS_PAGE;
        return;
      end
      if (l2[1:0] == 2'b01) begin  // Large page of 64 KB
        sub = r.vaddr[15:14];
        pa  = {l2[31:16], r.vaddr[15:0]};
      end else begin
        sub = r.vaddr[11:10];
        pa  = {l2[31:12], r.vaddr[11:0]};
      end
      case (sub)
        2'd0:    ap = l2[5:4];
        2'd1:    ap = l2[7:6];
        2'd2:    ap = l2[9:8];
        default: ap = l2[11:10];
      endcase
    end
    dv = shDacr[2 * dom +: 2];
    if (dv == 2'b00 || dv == 2'b10) begin
      f    = 1'b1;
      code = isPage ? FC_DOM_PAGE : FC_DOM_SEC;
    end else if (dv == 2'b01 && apDenied(ap, r.write, r.supervisor)) begin
      f    = 1'b1;
      code = isPage ? FC_PERM_PAGE : FC_PERM_SEC;
    end
  endfunction

  // ==================================================
  // Monitor sampled on the rising edge
  // ==================================================
  always @(posedge clk) begin : watch
    logic       expF;
    logic [3:0] expCode;
    domain_t    expDom;
    paddr_t     expPa;
    int         expReads;
    transReq_t  cur;
    paddr_t     expAddr;
    if (rstN) begin
      if (regCheckDue) begin
        regCheckDue = 1'b0;
        if (fsr !== expFsr) reportMismatch("fsr", expFsr, fsr);
        if (far !== expFar) reportMismatch("far", expFar, far);
      end
      if (cfgValid) begin
        case (cfg.regSel)
          REG_CTRL: {shR, shS, shEnable} = {cfg.data[9], cfg.data[8], cfg.data[0]};
          REG_TTB:  shTtb = {cfg.data[31:14], 14'b0};
          REG_DACR: shDacr = cfg.data;
          default:  ;
        endcase
      end
      if (creditReturn) begin
        creditCount++;
        if (creditCount > reqCount) reportError("credit returned with no request spent");
      end
      if (memReqValid) begin
        if (reqQ.size() == 0) begin
          reportError("descriptor read with no request in flight");
        end else begin
          expAddr = descAddr(reqQ[0], readsSeen);
          if (memAddr !== expAddr) reportMismatch("memAddr", expAddr, memAddr);
        end
        readsSeen++;
      end
      if (memRespValid) abortQ.push_back(memResp.extAbort);
      if (respValid) begin
        respCount++;
        if (reqQ.size() == 0) begin
          reportError("response with no request outstanding");
        end else begin
          cur = reqQ.pop_front();
          translate(cur, (abortQ.size() > 0) ? abortQ[0] : 1'b0,
                    (abortQ.size() > 1) ? abortQ[1] : 1'b0,
                    expF, expCode, expDom, expPa, expReads);
          if (readsSeen != expReads) begin
            reportError($sformatf("walk for vaddr %h made %0d reads instead of %0d",
                                  cur.vaddr, readsSeen, expReads));
          end
          if (creditCount < respCount) reportError("response arrived before its credit");
          if (resp.fault !== expF) reportMismatch("resp.fault", expF, resp.fault);
          if (expF && resp.faultCode !== expCode) begin
            reportMismatch("resp.faultCode", expCode, resp.faultCode);
          end
          if (!expF && resp.paddr !== expPa) reportMismatch("resp.paddr", expPa, resp.paddr);
          regCheckDue = 1'b1;  // Registers show it one cycle later
          if (expF) begin
            expFsr = {expDom, expCode};
            expFar = cur.vaddr;
          end
        end
        readsSeen = 0;
        abortQ.delete();
      end
      if (reqValid) begin
        reqQ.push_back(req);
        reqCount++;
        if (reqCount - respCount > QUEUE_DEPTH + 1) begin
          reportError("more requests in flight than credits");
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/mmuTb.sv
// Testbench top with clock, reset, random page tables, descriptor memory, stimulus, watchdog
`default_nettype none
`timescale 1ns/1ps

module mmuTb;
  import mmuPkg::*;

  localparam int QUEUE_DEPTH  = 4;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int BURSTS       = 3;
  localparam int TOTAL_REQS   = 24 + 40 + 4 * 24 + 3 * 20 + BURSTS * QUEUE_DEPTH;

  logic       clk = 1'b0;
  logic       rstN;
  logic       reqValid;
  transReq_t  req;
  logic       creditReturn;
  logic       respValid;
  transResp_t resp;
  logic       memReqValid;
  paddr_t     memAddr;
  logic       memRespValid = 1'b0;
  memResp_t   memResp      = '0;
  logic       cfgValid;
  cfgWrite_t  cfg;
  logic [7:0] fsr;
  vaddr_t     far;

  desc_t mem [4096];       // L1 table at word 0, coarse tables from word 256
  int    spent       = 0;  // Credits used so far
  int    creditsBack = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mmuTop #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
    .clk, .rstN, .reqValid, .req, .creditReturn, .respValid, .resp,
    .memReqValid, .memAddr, .memRespValid, .memResp, .cfgValid, .cfg, .fsr, .far
  );

  mmuChecker #(.QUEUE_DEPTH(QUEUE_DEPTH)) uChecker (
    .clk, .rstN, .reqValid, .req, .creditReturn, .respValid, .resp,
    .memReqValid, .memAddr, .memRespValid, .memResp, .cfgValid, .cfg, .fsr, .far
  );

  bind tableWalker walkerProps walkerPropsI (
    .clk, .rstN, .memReqValid, .memRespValid, .respValid
  );
  bind transReqQueue queueProps #(.QUEUE_DEPTH(QUEUE_DEPTH), .CNT_W(CNT_W)) queuePropsI (
    .clk, .rstN, .count
  );

  always @(posedge clk) begin
    if (creditReturn) creditsBack <= creditsBack + 1;
  end

  // ==================================================
  // Descriptor memory with 1 to 5 cycle latency
  // ==================================================
  always begin : memModel
    int     delay;
    paddr_t addr;
    @(posedge clk);
    if (memReqValid) begin
      addr  = memAddr;
      delay = 1 + $urandom % 5;
      repeat (delay - 1) @(posedge clk);
      #1;
      memRespValid     = 1'b1;
      memResp.data     = mem[addr[13:2]];
      memResp.extAbort = ($urandom % 16) == 0;  // Abort about 1 in 16
      @(posedge clk);
      #1;
      memRespValid = 1'b0;
    end
  end

  // Type 10 is a section or small page and 01 a coarse table or large page
  task automatic fillTables();
    logic [2:0] pick;
    desc_t      word;
    for (int i = 0; i < 4096; i++) begin
      word = $urandom;
      pick = 3'($urandom);
      case (pick)
        3'd0:             word[1:0] = 2'b00;
        3'd1:             word[1:0] = 2'b11;  // Fine or tiny is unsupported
        3'd2, 3'd3, 3'd4: word[1:0] = 2'b10;
        default:          word[1:0] = 2'b01;
      endcase
      if (i < 64 && word[1:0] == 2'b01) begin
        word[31:10] = 22'(1 + $urandom % 15);  // Coarse table k at word 256*k
      end
      mem[i] = word;
    end
  endtask

  function automatic logic [31:0] ctrlWord(input logic en, input logic s, input logic r);
    return {22'b0, r, s, 7'b0, en};
  endfunction

  function automatic transReq_t randomReq(input logic mapped);
    transReq_t r;
    r.vaddr = $urandom;
    {r.write, r.supervisor, r.dataAccess, r.wordAccess} = 4'($urandom);
    if (mapped) r.vaddr[31:20] = 12'($urandom % 64);  // Stay inside the 64 sections
    if (r.wordAccess && ($urandom % 4) != 0) r.vaddr[1:0] = 2'b00;
    return r;
  endfunction

  // ==================================================
  // Driving tasks called 1 ns after a rising edge
  // ==================================================
  task automatic writeCfg(input regSel_t sel, input logic [31:0] data);
    cfgValid   = 1'b1;
    cfg.regSel = sel;
    cfg.data   = data;
    @(posedge clk);
    #1;
    cfgValid = 1'b0;
  endtask

  task automatic sendReq(input transReq_t r);
    while (QUEUE_DEPTH - spent + creditsBack == 0) begin  // Out of credits
      @(posedge clk);
      #1;
    end
    reqValid = 1'b1;
    req      = r;
    spent++;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic runBatch(input int n, input logic mapped, input int gapMax);
    for (int i = 0; i < n; i++) begin
      sendReq(randomReq(mapped));
      repeat ($urandom % (gapMax + 1)) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic waitDrain();
    while (uChecker.respCount != spent) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finishTest(input string name);
    waitDrain();
    repeat (2) begin  // Let the fault register check land
      @(posedge clk);
      #1;
    end
    uChecker.closeTest(name);
  endtask

  initial begin : stimulus
    int errs;
    void'($urandom(16511));
    rstN     = 1'b0;
    reqValid = 1'b0;
    req      = '0;
    cfgValid = 1'b0;
    cfg      = '0;
    fillTables();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;

    writeCfg(REG_TTB, 32'h0);
    runBatch(24, 1'b0, 2);  // MMU off with any address
    finishTest("disabled");

    writeCfg(REG_DACR, 32'hFFFF_FFFF);
    writeCfg(REG_CTRL, ctrlWord(1'b1, 1'b0, 1'b0));
    runBatch(40, 1'b1, 2);
    finishTest("manager");

    writeCfg(REG_DACR, 32'h5555_5555);  // All domains client so AP is always checked
    for (int sr = 0; sr < 4; sr++) begin
      writeCfg(REG_CTRL, ctrlWord(1'b1, sr[0], sr[1]));
      runBatch(24, 1'b1, 1);
      waitDrain();  // S and R only change with nothing in flight
    end
    finishTest("client");

    for (int k = 0; k < 3; k++) begin
      writeCfg(REG_DACR, $urandom);
      writeCfg(REG_CTRL, ctrlWord(1'b1, 1'($urandom), 1'($urandom)));
      runBatch(20, 1'b1, 1);
      finishTest("mixed");
    end

    for (int b = 0; b < BURSTS; b++) begin
      runBatch(QUEUE_DEPTH, 1'b1, 0);  // Back to back using all credits
      finishTest("burst");
    end

    errs = uChecker.errCount + dut_i.uWalker.walkerPropsI.readFails +
           dut_i.uWalker.walkerPropsI.respFails + dut_i.uQueue.queuePropsI.depthFails;
    $display("Summary: %0d requests, %0d responses, %0d errors",
             spent, uChecker.respCount, errs);
    if (errs == 0 && uChecker.respCount == TOTAL_REQS) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // 200 cycles per request
  initial begin : watchdog
    #((RESET_CYCLES + TOTAL_REQS * 200) * CLK_PERIOD);
    $display("Watchdog expired with %0d of %0d responses", uChecker.respCount, TOTAL_REQS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/mmuPkg.sv
hw/transReqQueue.sv
hw/tableWalker.sv
hw/faultDetect.sv
hw/faultStatusRegs.sv
hw/mmuTop.sv
tb/mmuProps.sv
tb/mmuChecker.sv
tb/mmuTb.sv

// File: Bender.yml
package:
  name: mmu

sources:
  - hw/mmuPkg.sv
  - hw/transReqQueue.sv
  - hw/tableWalker.sv
  - hw/faultDetect.sv
  - hw/faultStatusRegs.sv
  - hw/mmuTop.sv
  - target: simulation
    files:
      - tb/mmuProps.sv
      - tb/mmuChecker.sv
      - tb/mmuTb.sv
